// ==== hw/memTypesPkg.sv ====
package memTypesPkg;

    // byte address into the shared RAM
    localparam int AddrWidth = 17;

    // core data word and instruction word
    localparam int DataWidth = 32;

    // RAM port is one byte wide
    localparam int ByteWidth = 8;

    // pc step per instruction
    localparam int InstBytes = 4;

    localparam int RamDepth = 1 << AddrWidth;

endpackage

// ==== hw/memOpPkg.sv ====
package memOpPkg;

    // data path access size code
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLenT;

    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stFetch = 2'd1,
        stLoad  = 2'd2,
        stStore = 2'd3
    } ctrlStateT;

    // byte count per size code, unused code treated as one byte
    localparam logic [2:0] lenBytes [4] = '{3'd1, 3'd2, 3'd4, 3'd1};

endpackage

// ==== hw/byteRam.sv ====
`timescale 1ns/1ps

module byteRam
    import memTypesPkg::*;
(
    input  logic                 clk,
    input  logic                 memWe,
    input  logic [AddrWidth-1:0] memAddr,
    input  logic [ByteWidth-1:0] memWrData,
    output logic [ByteWidth-1:0] memRdData
);

    logic [ByteWidth-1:0] mem [RamDepth];

    // power-up contents are zero
    initial begin
        for (int i = 0; i < RamDepth; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old byte on a write to the same address
    always @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memWrData;
        end
        memRdData <= mem[memAddr];
    end

endmodule

// ==== hw/instFetchUnit.sv ====
`timescale 1ns/1ps

module instFetchUnit
    import memTypesPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 jumpEn,
    input  logic [AddrWidth-1:0] jumpAddr,
    input  logic                 instTaken,
    input  logic                 fetchDone,
    input  logic [DataWidth-1:0] fetchInst,
    output logic                 fetchEn,
    output logic [AddrWidth-1:0] fetchAddr,
    output logic                 instValid,
    output logic [AddrWidth-1:0] instAddr,
    output logic [DataWidth-1:0] instData
);

    logic [AddrWidth-1:0] pc;
    // a fetch for the old stream may still be in flight
    logic                 discard;
    logic                 keepFetch;

    assign fetchEn   = !instValid && !jumpEn;
    assign fetchAddr = pc;
    assign keepFetch = fetchDone && !discard && !jumpEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            instValid <= 1'b0;
            discard   <= 1'b0;
        end else if (rdy) begin
            if (jumpEn) begin
                pc        <= jumpAddr;
                instValid <= 1'b0;
                // empty slot without a done this cycle means a request is open
                discard   <= !instValid && !fetchDone;
            end else if (fetchDone) begin
                if (discard) begin
                    discard <= 1'b0;
                end else begin
                    instValid <= 1'b1;
                    pc        <= pc + AddrWidth'(InstBytes);
                end
            end else if (instValid && instTaken) begin
                instValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && keepFetch) begin
            instAddr <= pc;
            instData <= fetchInst;
        end
    end

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl
    import memTypesPkg::*;
    import memOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  logic                 fetchEn,
    input  logic [AddrWidth-1:0] fetchAddr,
    input  logic                 dcEn,
    input  logic                 dcStore,
    input  accessLenT            dcLen,
    input  logic [AddrWidth-1:0] dcAddr,
    input  logic [DataWidth-1:0] dcWrData,
    input  logic [ByteWidth-1:0] memRdData,
    output logic                 fetchDone,
    output logic [DataWidth-1:0] fetchInst,
    output logic                 dcDone,
    output logic [DataWidth-1:0] dcRdData,
    output logic                 memWe,
    output logic [AddrWidth-1:0] memAddr,
    output logic [ByteWidth-1:0] memWrData
);

    ctrlStateT            state;
    logic [2:0]           stage;
    logic [2:0]           byteCnt;
    logic [AddrWidth-1:0] baseAddr;
    logic [DataWidth-1:0] wrData;
    logic [DataWidth-1:0] asmWord;
    logic [AddrWidth-1:0] lastAddr;

    logic                 active;
    logic                 canAccept;
    logic [1:0]           byteIdx;
    logic [AddrWidth-1:0] issueAddr;
    logic                 issueWe;
    logic [ByteWidth-1:0] issueData;
    logic [DataWidth-1:0] assembled;

    assign active = rdy && !ioBufferFull;

    // the cycle holding a done pulse counts as the idle gap
    assign canAccept = (state == stIdle) && !dcDone && !fetchDone;

    // byte returned now belongs to the address of the previous stage
    assign byteIdx = 2'(stage - 3'd1);

    always_comb begin
        issueWe   = 1'b0;
        issueData = dcWrData[ByteWidth-1:0];
        assembled = asmWord;
        assembled[byteIdx*ByteWidth +: ByteWidth] = memRdData;
        if (state == stIdle) begin
            issueAddr = dcEn ? dcAddr : fetchAddr;
            // store writes byte 0 in the accept cycle
            issueWe   = canAccept && dcEn && dcStore;
        end else begin
            issueAddr = baseAddr + AddrWidth'(stage);
            if (state == stStore) begin
                issueWe   = 1'b1;
                issueData = wrData[stage*ByteWidth +: ByteWidth];
            end
        end
    end

    // frozen cycles repeat the last address so the registered read stays valid
    assign memAddr   = active ? issueAddr : lastAddr;
    assign memWe     = active && issueWe;
    assign memWrData = issueData;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            stage     <= '0;
            dcDone    <= 1'b0;
            fetchDone <= 1'b0;
            lastAddr  <= '0;
        end else if (active) begin
            lastAddr  <= memAddr;
            dcDone    <= 1'b0;
            fetchDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (canAccept && dcEn) begin
                        stage <= 3'd1;
                        if (!dcStore) begin
                            state <= stLoad;
                        end else if (lenBytes[dcLen] == 3'd1) begin
                            dcDone <= 1'b1;
                        end else begin
                            state <= stStore;
                        end
                    end else if (canAccept && fetchEn) begin
                        stage <= 3'd1;
                        state <= stFetch;
                    end
                end
                stLoad, stFetch: begin
                    if (stage == byteCnt) begin
                        state <= stIdle;
                        if (state == stLoad) begin
                            dcDone <= 1'b1;
                        end else begin
                            fetchDone <= 1'b1;
                        end
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                stStore: begin
                    if (stage == byteCnt - 3'd1) begin
                        state  <= stIdle;
                        dcDone <= 1'b1;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // request fields and assembled words
    always_ff @(posedge clk) begin
        if (active) begin
            if (canAccept && dcEn) begin
                baseAddr <= dcAddr;
                byteCnt  <= lenBytes[dcLen];
                wrData   <= dcWrData;
                asmWord  <= '0;
            end else if (canAccept && fetchEn) begin
                baseAddr <= fetchAddr;
                byteCnt  <= 3'(InstBytes);
                asmWord  <= '0;
            end else if (state == stLoad || state == stFetch) begin
                asmWord <= assembled;
                if (stage == byteCnt && state == stLoad) begin
                    dcRdData <= assembled;
                end
                if (stage == byteCnt && state == stFetch) begin
                    fetchInst <= assembled;
                end
            end
        end
    end

endmodule

// ==== hw/memSubsys.sv ====
`timescale 1ns/1ps

module memSubsys
    import memTypesPkg::*;
    import memOpPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  logic                 jumpEn,
    input  logic [AddrWidth-1:0] jumpAddr,
    input  logic                 instTaken,
    input  logic                 dcEn,
    input  logic                 dcStore,
    input  accessLenT            dcLen,
    input  logic [AddrWidth-1:0] dcAddr,
    input  logic [DataWidth-1:0] dcWrData,
    output logic                 instValid,
    output logic [AddrWidth-1:0] instAddr,
    output logic [DataWidth-1:0] instData,
    output logic                 dcDone,
    output logic [DataWidth-1:0] dcRdData
);

    logic                 fetchEn;
    logic [AddrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [DataWidth-1:0] fetchInst;
    logic                 memWe;
    logic [AddrWidth-1:0] memAddr;
    logic [ByteWidth-1:0] memWrData;
    logic [ByteWidth-1:0] memRdData;

    // fetch side stalls together with the controller
    logic                 fetchRun;

    assign fetchRun = rdy && !ioBufferFull;

    instFetchUnit i_instFetchUnit (
        .clk       (clk),
        .rst       (rst),
        .rdy       (fetchRun),
        .jumpEn    (jumpEn),
        .jumpAddr  (jumpAddr),
        .instTaken (instTaken),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .instValid (instValid),
        .instAddr  (instAddr),
        .instData  (instData)
    );

    memCtrl i_memCtrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .dcEn         (dcEn),
        .dcStore      (dcStore),
        .dcLen        (dcLen),
        .dcAddr       (dcAddr),
        .dcWrData     (dcWrData),
        .memRdData    (memRdData),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dcDone       (dcDone),
        .dcRdData     (dcRdData),
        .memWe        (memWe),
        .memAddr      (memAddr),
        .memWrData    (memWrData)
    );

    byteRam i_byteRam (
        .clk       (clk),
        .memWe     (memWe),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRdData (memRdData)
    );

endmodule

// ==== sim/memChecker.sv ====
`timescale 1ns/1ps

module memChecker
    import memTypesPkg::*;
    import memOpPkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 rdy,
    input logic                 ioBufferFull,
    input logic                 jumpEn,
    input logic [AddrWidth-1:0] jumpAddr,
    input logic                 instTaken,
    input logic                 dcEn,
    input logic                 dcStore,
    input accessLenT            dcLen,
    input logic [AddrWidth-1:0] dcAddr,
    input logic [DataWidth-1:0] dcWrData,
    input logic                 instValid,
    input logic [AddrWidth-1:0] instAddr,
    input logic [DataWidth-1:0] instData,
    input logic                 dcDone,
    input logic [DataWidth-1:0] dcRdData
);

    // bytes never written read as zero, like the cleared RAM
    logic [ByteWidth-1:0] model [int];
    logic [AddrWidth-1:0] expPc = '0;
    logic [DataWidth-1:0] instWord = '0;
    logic                 lastRst = 1'b0;
    logic                 lastFrozen = 1'b0;
    logic                 lastValid = 1'b0;
    logic                 lastDone = 1'b0;
    logic [AddrWidth-1:0] lastAddr = '0;
    logic [DataWidth-1:0] lastData = '0;
    logic [DataWidth-1:0] lastRd = '0;
    int                   waitCnt = 0;
    int                   waitFetches = 0;
    int                   errCount = 0;
    int                   opCount = 0;
    int                   fetchCount = 0;

    // little-endian read, upper bytes stay zero
    function automatic logic [DataWidth-1:0] readModel(
        input logic [AddrWidth-1:0] addr,
        input int                   n
    );
        logic [DataWidth-1:0] word;
        logic [AddrWidth-1:0] a;
        word = '0;
        for (int i = 0; i < n; i++) begin
            a = addr + AddrWidth'(i);
            if (model.exists(int'(a))) begin
                word[i*ByteWidth +: ByteWidth] = model[int'(a)];
            end
        end
        return word;
    endfunction

    always @(posedge clk) begin
        logic                 frozen;
        logic                 rise;
        int                   nBytes;
        logic [DataWidth-1:0] expWord;
        logic [AddrWidth-1:0] a;
        frozen  = !rdy || ioBufferFull;
        rise    = instValid && !lastValid;
        nBytes  = (dcLen == lenByte) ? 1 : ((dcLen == lenHalf) ? 2 : 4);
        expWord = readModel(dcAddr, nBytes);
        if (lastRst && (instValid !== 1'b0 || dcDone !== 1'b0)) begin
            $display("instValid or dcDone is high during or right after reset");
            errCount++;
        end
        // values seen now must match the ones from before a frozen edge
        if (!rst && !lastRst && lastFrozen
                && (instValid !== lastValid || dcDone !== lastDone || instAddr !== lastAddr
                || instData !== lastData || dcRdData !== lastRd)) begin
            $display("outputs changed across a frozen cycle");
            errCount++;
        end
        // new instruction holds the memory word of its fetch
        if (rise) begin
            instWord = readModel(instAddr, InstBytes);
        end
        if (!rst && dcEn && !dcDone && rise) begin
            waitFetches++;
            if (waitFetches == 2) begin
                $display("a second fetch completed while a data request was waiting");
                errCount++;
            end
        end
        if (rst) begin
            expPc       = '0;
            waitCnt     = 0;
            waitFetches = 0;
        end else if (!frozen) begin
            if (jumpEn) begin
                expPc = jumpAddr;
            end else if (instValid && instTaken) begin
                if (instAddr !== expPc) begin
                    $display("Mismatch instAddr: got 0x%05h expected 0x%05h", instAddr, expPc);
                    errCount++;
                end
                if (instData !== instWord) begin
                    $display("Mismatch instData at 0x%05h: got 0x%08h expected 0x%08h",
                        instAddr, instData, instWord);
                    errCount++;
                end
                expPc = expPc + AddrWidth'(InstBytes);
                fetchCount++;
            end
            if (dcEn && dcDone) begin
                if (!dcStore && dcRdData !== expWord) begin
                    $display("Mismatch dcRdData at 0x%05h: got 0x%08h expected 0x%08h",
                        dcAddr, dcRdData, expWord);
                    errCount++;
                end
                if (dcStore) begin
                    for (int i = 0; i < nBytes; i++) begin
                        a = dcAddr + AddrWidth'(i);
                        model[int'(a)] = dcWrData[i*ByteWidth +: ByteWidth];
                    end
                end
                opCount++;
                $display("op %0d %s of %0d bytes at 0x%05h finished", opCount,
                    dcStore ? "store" : "load", nBytes, dcAddr);
                waitCnt     = 0;
                waitFetches = 0;
            end else if (dcEn) begin
                waitCnt++;
                if (waitCnt == 11) begin
                    $display("no dcDone within 10 active cycles for request at 0x%05h", dcAddr);
                    errCount++;
                end
            end else begin
                waitCnt     = 0;
                waitFetches = 0;
            end
        end
        lastRst    = rst;
        lastFrozen = frozen;
        lastValid  = instValid;
        lastDone   = dcDone;
        lastAddr   = instAddr;
        lastData   = instData;
        lastRd     = dcRdData;
    end

endmodule

// ==== sim/memSubsysTb.sv ====
`timescale 1ns/1ps

module memSubsysTb
    import memTypesPkg::*;
    import memOpPkg::*;
();

    localparam int NumOps = 200;
    // operations times worst-case access times stall margin
    localparam int MaxCycles = NumOps * 10 * 3;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 ioBufferFull;
    logic                 jumpEn;
    logic [AddrWidth-1:0] jumpAddr;
    logic                 instTaken;
    logic                 dcEn;
    logic                 dcStore;
    accessLenT            dcLen;
    logic [AddrWidth-1:0] dcAddr;
    logic [DataWidth-1:0] dcWrData;
    logic                 instValid;
    logic [AddrWidth-1:0] instAddr;
    logic [DataWidth-1:0] instData;
    logic                 dcDone;
    logic [DataWidth-1:0] dcRdData;

    int                   seed;
    int                   cycles = 0;
    int                   opsLeft;
    logic                 doneSeen;

    memSubsys i_memSubsys (.*);

    memChecker i_memChecker (.*);

    always begin
        clk = 1'b0;
        #10;
        clk = 1'b1;
        #10;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("run did not finish within %0d cycles", MaxCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic randomizeCoreSide();
        rdy          = ({$random(seed)} % 10) != 0;
        ioBufferFull = ({$random(seed)} % 20) == 0;
        instTaken    = ({$random(seed)} % 2) == 0;
        jumpEn       = ({$random(seed)} % 20) == 0;
        jumpAddr     = AddrWidth'(({$random(seed)} % 32) * 4);
    endtask

    // data addresses share a small window with the jump targets
    task automatic startDataRequest();
        dcEn     = 1'b1;
        dcStore  = ({$random(seed)} % 2) == 1;
        dcLen    = accessLenT'(2'({$random(seed)} % 3));
        dcAddr   = AddrWidth'(32'h40 + ({$random(seed)} % 64));
        dcWrData = $random(seed);
    endtask

    initial begin
        seed         = 32'h14e9;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        jumpEn       = 1'b0;
        jumpAddr     = '0;
        instTaken    = 1'b0;
        dcEn         = 1'b0;
        dcStore      = 1'b0;
        dcLen        = lenByte;
        dcAddr       = '0;
        dcWrData     = '0;
        doneSeen     = 1'b0;
        opsLeft      = NumOps;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (opsLeft > 0 || dcEn) begin
            if (doneSeen) begin
                dcEn = 1'b0;
            end
            if (!dcEn && opsLeft > 0 && ({$random(seed)} % 4) != 0) begin
                startDataRequest();
                opsLeft--;
            end
            randomizeCoreSide();
            // done is taken only at an edge that is not frozen
            doneSeen = dcEn && dcDone && rdy && !ioBufferFull;
            @(negedge clk);
        end
        $display("ops %0d fetches %0d errors %0d", i_memChecker.opCount,
            i_memChecker.fetchCount, i_memChecker.errCount);
        if (i_memChecker.errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/memTypesPkg.sv
hw/memOpPkg.sv
hw/byteRam.sv
hw/instFetchUnit.sv
hw/memCtrl.sv
hw/memSubsys.sv
sim/memChecker.sv
sim/memSubsysTb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then look for the failure line in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module memSubsysTb -f flist.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
